//--- Bender.yml
package:
  name: nf2_reg_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/nf2_core_pkg.sv
      - source/reg_decoder.sv
      - source/device_id_regs.sv
      - source/port_frame_counters.sv
      - source/unused_regs.sv
      - source/nf2_reg_core.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/tb_nf2_reg_core.sv

//--- bench/nf2_reg_core_stim.txt
# T name | R addr expected | W addr data | F port length error | I cycles
# addr and data in hex; port, length (0 = random 8..64), error and cycles in decimal
T id_regs
I 5
R 000 4E460C0E
R 001 00010203
R 002 00000000
T unused_space
R 200 DEADBEEF
R FFF DEADBEEF
W 2A5 12345678
R 2A5 DEADBEEF
T good_frames
F 0 12 0
F 0 0 0
F 2 0 0
R 100 00000002
R 101 00000000
R 102 00000001
R 103 00000000
T error_frames
F 1 16 1
F 1 0 1
R 105 00000002
R 101 00000000
R 100 00000002
R 104 00000000
T counter_clear
W 100 FFFFFFFF
R 100 00000000
R 102 00000001
F 0 10 0
R 100 00000001
T back_to_back
W 001 00000000
R 001 00010203
W 103 AAAAAAAA
R 103 00000000

//--- bench/tb_nf2_reg_core.sv
`include "nf2_core_defs.svh"

module tb_nf2_reg_core;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ACK_TIMEOUT = 20;

   logic                       core_clk_int = 1'b0;
   logic                       rst;
   logic                       reg_req;
   logic                       reg_rd_wr_l;
   nf2_core_pkg::reg_addr_t    reg_addr;
   nf2_core_pkg::reg_data_t    reg_wr_data;
   logic                       reg_ack;
   nf2_core_pkg::reg_data_t    reg_rd_data;
   logic [`NUM_PORTS-1:0]      gmii_rx_dv;
   logic [`NUM_PORTS-1:0]      gmii_rx_er;

   integer seed = 15427;
   int     test_errs;
   int     pass_count;
   int     fail_count;
   int     test_open;
   string  cur_name;

   nf2_reg_core dut (
      .core_clk_int (core_clk_int),
      .rst          (rst),
      .reg_req      (reg_req),
      .reg_rd_wr_l  (reg_rd_wr_l),
      .reg_addr     (reg_addr),
      .reg_wr_data  (reg_wr_data),
      .reg_ack      (reg_ack),
      .reg_rd_data  (reg_rd_data),
      .gmii_rx_dv   (gmii_rx_dv),
      .gmii_rx_er   (gmii_rx_er)
   );

   always #5 core_clk_int = ~core_clk_int;

   // ----------------------------------------------------------------------
   // Bus and receive helpers, each starts and ends 1 ns after an edge
   // ----------------------------------------------------------------------

   // No ack may show up while the host is quiet
   task automatic idle_cycles(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(posedge core_clk_int);
         #1;
         assert (reg_ack == 1'b0) else begin
            $display("FAIL reg_ack expected %h got %h", 1'b0, reg_ack);
            test_errs++;
         end
      end
   endtask

   task automatic run_access(input logic                    rd,
                             input nf2_core_pkg::reg_addr_t addr,
                             input nf2_core_pkg::reg_data_t wdata,
                             input nf2_core_pkg::reg_data_t expected);
      int                      waited;
      int                      exp_lat;
      logic                    got_ack;
      nf2_core_pkg::reg_data_t got;
      // Counter block reads one stage later than the others
      if (addr[`REG_ADDR_WIDTH-1 -: `BLOCK_SEL_WIDTH] == `PORT_CNT_BLOCK) begin
         exp_lat = 4;
      end else begin
         exp_lat = 3;
      end
      reg_req     = 1'b1;
      reg_rd_wr_l = rd;
      reg_addr    = addr;
      reg_wr_data = wdata;
      waited      = 0;
      got_ack     = 1'b0;
      while (!got_ack && (waited < ACK_TIMEOUT)) begin
         @(posedge core_clk_int);
         #1;
         waited++;
         got_ack = reg_ack;
      end
      got     = reg_rd_data;
      reg_req = 1'b0;
      assert (got_ack) else begin
         $display("reg_ack never came for the %s of address %h",
                  rd ? "read" : "write", addr);
         test_errs++;
      end
      if (got_ack) begin
         assert (got == expected) else begin
            $display("FAIL reg_rd_data at address %h expected %h got %h",
                     addr, expected, got);
            test_errs++;
         end
         assert (waited == exp_lat) else begin
            $display("FAIL reg_ack latency at address %h expected %h got %h",
                     addr, exp_lat, waited);
            test_errs++;
         end
      end
      // Single low cycle of reg_req before the next access
      idle_cycles(1);
   endtask

   task automatic send_frame(input int port, input int len, input int err);
      int n;
      int i;
      n = len;
      // Zero length in the file asks for a random one
      if (n == 0) begin
         n = 8 + int'($unsigned($random(seed)) % 57);
      end
      for (i = 0; i < n; i++) begin
         gmii_rx_dv[port] = 1'b1;
         gmii_rx_er[port] = (err != 0) && (i == n / 2);
         @(posedge core_clk_int);
         #1;
      end
      gmii_rx_dv[port] = 1'b0;
      gmii_rx_er[port] = 1'b0;
      // Count lands the cycle after the falling edge is sampled
      idle_cycles(2);
   endtask

   task automatic end_test();
      if (test_open != 0) begin
         if (test_errs == 0) begin
            $display("test %s: pass", cur_name);
            pass_count++;
         end else begin
            $display("test %s: fail, %0d errors", cur_name, test_errs);
            fail_count++;
         end
      end
      test_open = 0;
      test_errs = 0;
   endtask

   // ----------------------------------------------------------------------
   // Main sequence from the stimulus file
   // ----------------------------------------------------------------------
   initial begin
      string                   line;
      string                   tname;
      int                      fd;
      int                      n;
      int                      a_port;
      int                      a_len;
      int                      a_err;
      int                      file_ok;
      int                      stray_errs;
      byte                     op;
      nf2_core_pkg::reg_addr_t addr_v;
      nf2_core_pkg::reg_data_t data_v;

      rst         = 1'b1;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b1;
      reg_addr    = '0;
      reg_wr_data = '0;
      gmii_rx_dv  = '0;
      gmii_rx_er  = '0;
      test_errs   = 0;
      pass_count  = 0;
      fail_count  = 0;
      test_open   = 0;
      file_ok     = 1;
      stray_errs  = 0;

      repeat (10) begin
         @(posedge core_clk_int);
      end
      #1;
      rst = 1'b0;

      fd = $fopen("bench/nf2_reg_core_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file");
         file_ok = 0;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0) begin
               op = line.getc(0);
               case (op)
                  "T": begin
                     end_test();
                     n = $sscanf(line, "T %s", tname);
                     cur_name  = tname;
                     test_open = 1;
                  end
                  "R": begin
                     n = $sscanf(line, "R %h %h", addr_v, data_v);
                     run_access(1'b1, addr_v, '0, data_v);
                  end
                  // Writes always hand back zero
                  "W": begin
                     n = $sscanf(line, "W %h %h", addr_v, data_v);
                     run_access(1'b0, addr_v, data_v, '0);
                  end
                  "F": begin
                     n = $sscanf(line, "F %d %d %d", a_port, a_len, a_err);
                     send_frame(a_port, a_len, a_err);
                  end
                  "I": begin
                     n = $sscanf(line, "I %d", a_len);
                     idle_cycles(a_len);
                  end
                  default: ;
               endcase
            end
         end
         $fclose(fd);
      end

      // Errors seen before any test line still count against the run
      if (test_open == 0) begin
         stray_errs = test_errs;
      end
      end_test();

      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if ((fail_count == 0) && (stray_errs == 0) && (file_ok != 0) && (pass_count > 0)) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- source/device_id_regs.sv
`include "nf2_core_defs.svh"

module device_id_regs (
   input  logic                    core_clk_int,
   input  logic                    rst,
   input  logic                    blk_req,
   input  logic                    blk_rd_wr_l,
   input  nf2_core_pkg::reg_word_t blk_word,
   output logic                    blk_ack,
   output nf2_core_pkg::reg_data_t blk_rd_data
);

   nf2_core_pkg::reg_data_t id_word;

   // Identification map
   always_comb begin
      case (blk_word)
         nf2_core_pkg::reg_word_t'(0): id_word = `DEV_ID_VALUE;
         nf2_core_pkg::reg_word_t'(1): id_word = `DEV_VERSION_VALUE;
         default:                      id_word = '0;
      endcase
   end

   always_ff @(posedge core_clk_int) begin
      if (rst) begin
         blk_ack <= 1'b0;
      end else begin
         blk_ack <= blk_req;
      end
   end

   // Read-only block, a write only gets its ack
   always_ff @(posedge core_clk_int) begin
      if (blk_req) begin
         blk_rd_data <= blk_rd_wr_l ? id_word : '0;
      end
   end

endmodule

//--- source/nf2_core_defs.svh
`ifndef NF2_CORE_DEFS_SVH
`define NF2_CORE_DEFS_SVH

// ----------------------------------------------------------------------
// Register bus widths
// ----------------------------------------------------------------------
`define REG_ADDR_WIDTH     12
`define REG_DATA_WIDTH     32

// Upper address bits pick the block, lower bits the word inside it
`define BLOCK_SEL_WIDTH    4
`define WORD_ADDR_WIDTH    8

// Receive ports served by the frame counter block
`define NUM_PORTS          4

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------
`define DEV_ID_BLOCK       4'h0
`define PORT_CNT_BLOCK     4'h1

// ----------------------------------------------------------------------
// Fixed register values
// ----------------------------------------------------------------------
`define DEV_ID_VALUE       32'h4E46_0C0E

// Byte 2 major, byte 1 minor, byte 0 revision
`define DEV_VERSION_VALUE  32'h0001_0203

`define UNUSED_RD_DATA     32'hDEAD_BEEF

`endif

//--- source/nf2_core_pkg.sv
`include "nf2_core_defs.svh"

package nf2_core_pkg;

   // ----------------------------------------------------------------------
   // Register bus types
   // ----------------------------------------------------------------------

   // Full host-side register address
   typedef logic [`REG_ADDR_WIDTH-1:0]  reg_addr_t;

   // Block number taken from the top of the address
   typedef logic [`BLOCK_SEL_WIDTH-1:0] blk_sel_t;

   // Word index inside one block
   typedef logic [`WORD_ADDR_WIDTH-1:0] reg_word_t;

   typedef logic [`REG_DATA_WIDTH-1:0]  reg_data_t;

   // ----------------------------------------------------------------------
   // Receive side
   // ----------------------------------------------------------------------

   // Enough bits to name any receive port
   typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;

endpackage

//--- source/nf2_reg_core.sv
`include "nf2_core_defs.svh"

module nf2_reg_core (
   input  logic                       core_clk_int,
   input  logic                       rst,

   // Host register bus
   input  logic                       reg_req,
   input  logic                       reg_rd_wr_l,
   input  logic [`REG_ADDR_WIDTH-1:0] reg_addr,
   input  logic [`REG_DATA_WIDTH-1:0] reg_wr_data,
   output logic                       reg_ack,
   output logic [`REG_DATA_WIDTH-1:0] reg_rd_data,

   // Receive strobes, one bit per port
   input  logic [`NUM_PORTS-1:0]      gmii_rx_dv,
   input  logic [`NUM_PORTS-1:0]      gmii_rx_er
);

   logic                       id_req;
   logic                       id_ack;
   logic [`REG_DATA_WIDTH-1:0] id_rd_data;
   logic                       cnt_req;
   logic                       cnt_ack;
   logic [`REG_DATA_WIDTH-1:0] cnt_rd_data;
   logic                       unused_req;
   logic                       unused_ack;
   logic [`REG_DATA_WIDTH-1:0] unused_rd_data;
   logic                       blk_rd_wr_l;
   logic [`WORD_ADDR_WIDTH-1:0] blk_word;
   logic [`REG_DATA_WIDTH-1:0] blk_wr_data;

   // ----------------------------------------------------------------------
   // Single-level address decode
   // ----------------------------------------------------------------------
   reg_decoder decoder (
      .core_clk_int   (core_clk_int),
      .rst            (rst),
      .reg_req        (reg_req),
      .reg_rd_wr_l    (reg_rd_wr_l),
      .reg_addr       (reg_addr),
      .reg_wr_data    (reg_wr_data),
      .reg_ack        (reg_ack),
      .reg_rd_data    (reg_rd_data),
      .id_req         (id_req),
      .id_ack         (id_ack),
      .id_rd_data     (id_rd_data),
      .cnt_req        (cnt_req),
      .cnt_ack        (cnt_ack),
      .cnt_rd_data    (cnt_rd_data),
      .unused_req     (unused_req),
      .unused_ack     (unused_ack),
      .unused_rd_data (unused_rd_data),
      .blk_rd_wr_l    (blk_rd_wr_l),
      .blk_word       (blk_word),
      .blk_wr_data    (blk_wr_data)
   );

   // ----------------------------------------------------------------------
   // Register blocks
   // ----------------------------------------------------------------------
   device_id_regs dev_id (
      .core_clk_int (core_clk_int),
      .rst          (rst),
      .blk_req      (id_req),
      .blk_rd_wr_l  (blk_rd_wr_l),
      .blk_word     (blk_word),
      .blk_ack      (id_ack),
      .blk_rd_data  (id_rd_data)
   );

   // Stands in for the MAC group registers
   port_frame_counters frame_cnt (
      .core_clk_int (core_clk_int),
      .rst          (rst),
      .blk_req      (cnt_req),
      .blk_rd_wr_l  (blk_rd_wr_l),
      .blk_word     (blk_word),
      .blk_wr_data  (blk_wr_data),
      .gmii_rx_dv   (gmii_rx_dv),
      .gmii_rx_er   (gmii_rx_er),
      .blk_ack      (cnt_ack),
      .blk_rd_data  (cnt_rd_data)
   );

   unused_regs unused (
      .core_clk_int (core_clk_int),
      .rst          (rst),
      .blk_req      (unused_req),
      .blk_ack      (unused_ack),
      .blk_rd_data  (unused_rd_data)
   );

endmodule

//--- source/port_frame_counters.sv
`include "nf2_core_defs.svh"

module port_frame_counters (
   input  logic                    core_clk_int,
   input  logic                    rst,
   input  logic                    blk_req,
   input  logic                    blk_rd_wr_l,
   input  nf2_core_pkg::reg_word_t blk_word,
   // Any write clears, so the value itself is never looked at
   input  nf2_core_pkg::reg_data_t blk_wr_data,
   input  logic [`NUM_PORTS-1:0]   gmii_rx_dv,
   input  logic [`NUM_PORTS-1:0]   gmii_rx_er,
   output logic                    blk_ack,
   output nf2_core_pkg::reg_data_t blk_rd_data
);

   nf2_core_pkg::reg_data_t   good_view [`NUM_PORTS];
   nf2_core_pkg::reg_data_t   err_view  [`NUM_PORTS];
   nf2_core_pkg::port_idx_t   pidx;
   logic                      err_word;
   logic                      in_range;
   logic                      wr_hit;
   logic                      rd_stage;
   nf2_core_pkg::reg_data_t   rd_next;

   assign wr_hit   = blk_req && !blk_rd_wr_l;
   assign pidx     = blk_word[$bits(nf2_core_pkg::port_idx_t)-1:0];
   assign err_word = blk_word[$bits(nf2_core_pkg::port_idx_t)];
   assign in_range = (blk_word < nf2_core_pkg::reg_word_t'(2 * `NUM_PORTS));

   // ----------------------------------------------------------------------
   // Per-port frame detection and counting
   // ----------------------------------------------------------------------
   for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
      logic                    dv_q;
      logic                    err_seen;
      logic                    frame_end;
      logic                    clr_good;
      logic                    clr_err;
      nf2_core_pkg::reg_data_t good_cnt;
      nf2_core_pkg::reg_data_t err_cnt;

      // Falling edge of rx_dv closes the frame
      assign frame_end = dv_q && !gmii_rx_dv[p];
      assign clr_good  = wr_hit && (blk_word == nf2_core_pkg::reg_word_t'(p));
      assign clr_err   = wr_hit && (blk_word == nf2_core_pkg::reg_word_t'(p + `NUM_PORTS));

      always_ff @(posedge core_clk_int) begin
         if (rst) begin
            dv_q     <= 1'b0;
            err_seen <= 1'b0;
            good_cnt <= '0;
            err_cnt  <= '0;
         end else begin
            dv_q <= gmii_rx_dv[p];
            if (frame_end) begin
               err_seen <= 1'b0;
            end else if (gmii_rx_dv[p] && gmii_rx_er[p]) begin
               err_seen <= 1'b1;
            end
            // Clear wins first, a frame closing now still lands
            if (clr_good) begin
               good_cnt <= nf2_core_pkg::reg_data_t'(frame_end && !err_seen);
            end else if (frame_end && !err_seen) begin
               good_cnt <= good_cnt + 1'b1;
            end
            if (clr_err) begin
               err_cnt <= nf2_core_pkg::reg_data_t'(frame_end && err_seen);
            end else if (frame_end && err_seen) begin
               err_cnt <= err_cnt + 1'b1;
            end
         end
      end

      assign good_view[p] = good_cnt;
      assign err_view[p]  = err_cnt;
   end

   // ----------------------------------------------------------------------
   // Register read, one stage of data then the ack
   // ----------------------------------------------------------------------
   always_comb begin
      rd_next = '0;
      if (in_range) begin
         rd_next = err_word ? err_view[pidx] : good_view[pidx];
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (rst) begin
         rd_stage <= 1'b0;
         blk_ack  <= 1'b0;
      end else begin
         rd_stage <= blk_req;
         blk_ack  <= rd_stage;
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (blk_req) begin
         blk_rd_data <= rd_next;
      end
   end

endmodule

//--- source/reg_decoder.sv
`include "nf2_core_defs.svh"

module reg_decoder (
   input  logic                    core_clk_int,
   input  logic                    rst,

   // Host side
   input  logic                    reg_req,
   input  logic                    reg_rd_wr_l,
   input  nf2_core_pkg::reg_addr_t reg_addr,
   input  nf2_core_pkg::reg_data_t reg_wr_data,
   output logic                    reg_ack,
   output nf2_core_pkg::reg_data_t reg_rd_data,

   // Per-block request and acknowledge
   output logic                    id_req,
   input  logic                    id_ack,
   input  nf2_core_pkg::reg_data_t id_rd_data,
   output logic                    cnt_req,
   input  logic                    cnt_ack,
   input  nf2_core_pkg::reg_data_t cnt_rd_data,
   output logic                    unused_req,
   input  logic                    unused_ack,
   input  nf2_core_pkg::reg_data_t unused_rd_data,

   // Shared block bus
   output logic                    blk_rd_wr_l,
   output nf2_core_pkg::reg_word_t blk_word,
   output nf2_core_pkg::reg_data_t blk_wr_data
);

   typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_DONE} state_t;

   state_t                  state;
   logic                    rearm;
   logic                    accept;
   nf2_core_pkg::reg_addr_t addr_q;
   logic                    rd_wr_l_q;
   nf2_core_pkg::reg_data_t wr_data_q;
   nf2_core_pkg::reg_data_t rd_data_q;
   nf2_core_pkg::blk_sel_t  blk_sel;
   logic                    sel_id;
   logic                    sel_cnt;
   logic                    sel_ack;
   nf2_core_pkg::reg_data_t sel_data;

   // ----------------------------------------------------------------------
   // Block decode from the latched address
   // ----------------------------------------------------------------------
   assign blk_sel = addr_q[`REG_ADDR_WIDTH-1 -: `BLOCK_SEL_WIDTH];
   assign sel_id  = (blk_sel == `DEV_ID_BLOCK);
   assign sel_cnt = (blk_sel == `PORT_CNT_BLOCK);

   always_comb begin
      if (sel_id) begin
         sel_ack  = id_ack;
         sel_data = id_rd_data;
      end else if (sel_cnt) begin
         sel_ack  = cnt_ack;
         sel_data = cnt_rd_data;
      end else begin
         sel_ack  = unused_ack;
         sel_data = unused_rd_data;
      end
   end

   // ----------------------------------------------------------------------
   // Access FSM
   // ----------------------------------------------------------------------

   // A request held past its ack waits here until it drops
   assign accept = (state == ST_IDLE) && reg_req && !rearm;

   always_ff @(posedge core_clk_int) begin
      if (rst) begin
         state <= ST_IDLE;
         rearm <= 1'b0;
      end else begin
         case (state)
            ST_IDLE:  if (accept) state <= ST_ISSUE;
            ST_ISSUE: state <= ST_WAIT;
            ST_WAIT:  if (sel_ack) state <= ST_DONE;
            ST_DONE:  state <= ST_IDLE;
            default:  state <= ST_IDLE;
         endcase
         // Only a request still high at the ack is held off
         if (!reg_req) begin
            rearm <= 1'b0;
         end else if (state == ST_DONE) begin
            rearm <= 1'b1;
         end
      end
   end

   // Access and result holding registers
   always_ff @(posedge core_clk_int) begin
      if (accept) begin
         addr_q    <= reg_addr;
         rd_wr_l_q <= reg_rd_wr_l;
         wr_data_q <= reg_wr_data;
      end
      // Writes hand back zero
      if ((state == ST_WAIT) && sel_ack) begin
         rd_data_q <= rd_wr_l_q ? sel_data : '0;
      end
   end

   // One-cycle request to the chosen block only
   assign id_req     = (state == ST_ISSUE) && sel_id;
   assign cnt_req    = (state == ST_ISSUE) && sel_cnt;
   assign unused_req = (state == ST_ISSUE) && !sel_id && !sel_cnt;

   assign blk_rd_wr_l = rd_wr_l_q;
   assign blk_word    = addr_q[`WORD_ADDR_WIDTH-1:0];
   assign blk_wr_data = wr_data_q;

   assign reg_ack     = (state == ST_DONE);
   assign reg_rd_data = rd_data_q;

endmodule

//--- source/unused_regs.sv
`include "nf2_core_defs.svh"

module unused_regs (
   input  logic                    core_clk_int,
   input  logic                    rst,
   input  logic                    blk_req,
   output logic                    blk_ack,
   output nf2_core_pkg::reg_data_t blk_rd_data
);

   // Ack everything so a stray address never hangs the host
   always_ff @(posedge core_clk_int) begin
      if (rst) begin
         blk_ack <= 1'b0;
      end else begin
         blk_ack <= blk_req;
      end
   end

   // Marker pattern, decoder zeroes it on writes
   assign blk_rd_data = `UNUSED_RD_DATA;

endmodule

//--- sources.f
+incdir+source
source/nf2_core_pkg.sv
source/reg_decoder.sv
source/device_id_regs.sv
source/port_frame_counters.sv
source/unused_regs.sv
source/nf2_reg_core.sv
bench/tb_nf2_reg_core.sv
